//--- project.f
+incdir+bench
hdl/ltssm_cfg_pkg.sv
hdl/cfg_timeout_timer.sv
hdl/ts_os_builder.sv
hdl/os_beat_tx.sv
hdl/cfg_state_ctrl.sv
hdl/ltssm_cfg_top.sv
bench/tb_ltssm_cfg.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_ltssm_cfg
FILELIST := project.f
OBJ_DIR  := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the simulation prints the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/tb_checks.svh
// ==================
// Testbench checks and set model
// ==================

// one symbol of the set layout, by symbol index 0 to 15
function automatic logic [7:0] model_symbol(os_kind_e kind, logic lane_valid, int idx);
  if (kind == OS_IDLE) begin
    return 8'h00;
  end
  case (idx)
    0: return SYM_COM;
    1: return LINK_NUM;
    2: return lane_valid ? 8'h00 : SYM_PAD;
    3: return N_FTS_VAL;
    4: return RATE_ID_VAL;
    5: return 8'h00;
    default: return (kind == OS_TS2) ? TS2_ID : TS1_ID;
  endcase
endfunction

function automatic os_word_t expected_word(os_kind_e kind, logic lane_valid, int beat);
  os_word_t w;
  for (int k = 0; k < 4; k++) begin
    w[8*k +: 8] = model_symbol(kind, lane_valid, 4 * beat + k);
  end
  return w;
endfunction

task automatic check_word(string what, os_word_t exp, os_word_t act);
  if (exp !== act) begin
    $display("CHECK FAILED %s: %s expected %08h actual %08h", test_name, what, exp, act);
    err_cnt++;
  end
endtask

task automatic check_kind(string what, os_kind_e exp, os_kind_e act);
  if (exp !== act) begin
    $display("CHECK FAILED %s: %s expected %s actual %s", test_name, what, exp.name(),
             act.name());
    err_cnt++;
  end
endtask

task automatic check_flag(string what, logic exp, logic act);
  if (exp !== act) begin
    $display("CHECK FAILED %s: %s expected %0b actual %0b", test_name, what, exp, act);
    err_cnt++;
  end
endtask

task automatic check_count(string what, int exp, int act);
  if (exp != act) begin
    $display("CHECK FAILED %s: %s expected %0d actual %0d", test_name, what, exp, act);
    err_cnt++;
  end
endtask

task automatic report_failure(string msg);
  $display("%s: %s", test_name, msg);
  err_cnt++;
endtask

//--- bench/tb_ltssm_cfg.sv
// ==================
// LTSSM Configuration testbench
// ==================
`timescale 1ns/10ps

module tb_ltssm_cfg
  import ltssm_cfg_pkg::*;
();

  localparam logic [7:0]  LINK_NUM      = 8'h05;
  localparam int          NUM_LANES     = 4;
  localparam logic [31:0] LONG_CYC      = 32'd400;
  localparam logic [31:0] SHORT_CYC     = 32'd150;
  localparam int          IDLE_SETS_MIN = 16;
  localparam logic [31:0] SEED          = 32'hab48_6359;
  // one set at 70 percent ready, plus the send bubble
  localparam int          SET_CYC       = BEATS_PER_OS * 10 / 7 + 2;
  localparam int          TEST_SETS     = 40;
  localparam int          WATCHDOG_CYC  =
    2 * (4 * TEST_SETS * SET_CYC + int'(LONG_CYC) + 2 * int'(SHORT_CYC));

  logic                 clk_i;
  logic                 rst_i;
  logic                 en;
  logic [NUM_LANES-1:0] width_sat;
  logic                 lanes_formed;
  logic                 nums_match;
  logic                 lane_reconfig;
  logic [NUM_LANES-1:0] complete_ts2;
  logic                 idle_rcvd;
  logic                 idle_sat;
  logic                 os_ready = 1'b0;
  os_word_t             os_data;
  logic                 os_valid;
  logic                 os_last;
  logic                 success;
  logic                 error;

  int       cyc = 0;
  int       err_cnt = 0;
  int       err_at_start;
  int       test_cnt = 0;
  string    test_name = "reset";
  int       start_edge;
  os_word_t set_words [4];
  int       beat_idx = 0;
  logic     stall_q = 1'b0;
  os_word_t held_data;
  logic     held_last;
  os_kind_e set_kinds [$];
  logic     set_lanes [$];
  int       last_done = 0;
  int       prev_done = 0;

  `include "tb_checks.svh"

  ltssm_cfg_top #(
    .LINK_NUM         (LINK_NUM),
    .NUM_LANES        (NUM_LANES),
    .LONG_TIMEOUT_CYC (LONG_CYC),
    .SHORT_TIMEOUT_CYC(SHORT_CYC),
    .IDLE_SETS_MIN    (IDLE_SETS_MIN)
  ) dut0 (
    .clk_i                  (clk_i),
    .rst_i                  (rst_i),
    .en_i                   (en),
    .link_width_satisfied_i (width_sat),
    .link_lanes_formed_i    (lanes_formed),
    .link_lanes_nums_match_i(nums_match),
    .link_lane_reconfig_i   (lane_reconfig),
    .config_complete_ts2_i  (complete_ts2),
    .single_idle_received_i (idle_rcvd),
    .link_idle_satisfied_i  (idle_sat),
    .os_ready_i             (os_ready),
    .os_data_o              (os_data),
    .os_valid_o             (os_valid),
    .os_last_o              (os_last),
    .success_o              (success),
    .error_o                (error)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // edge index, read at a rising edge as the value before it
  always @(posedge clk_i) begin
    cyc <= cyc + 1;
  end

  always @(posedge clk_i) begin
    os_ready <= ($urandom % 100) < 70;
  end

  // classify a finished set, then hold every beat against the model
  task automatic record_set();
    os_kind_e kind;
    logic     lane;
    if (set_words[3] == {4{TS2_ID}}) begin
      kind = OS_TS2;
    end else if (set_words[0][7:0] == SYM_COM) begin
      kind = OS_TS1;
    end else begin
      kind = OS_IDLE;
    end
    lane = (set_words[0][23:16] == 8'h00);
    for (int b = 0; b < 4; b++) begin
      check_word($sformatf("set %0d beat %0d", set_kinds.size(), b),
                 expected_word(kind, lane, b), set_words[b]);
    end
    set_kinds.push_back(kind);
    set_lanes.push_back(lane);
    prev_done = last_done;
    last_done = cyc;
  endtask

  // stream monitor
  always @(posedge clk_i) begin
    if (!rst_i) begin
      if (stall_q) begin
        check_flag("valid held under stall", 1'b1, os_valid);
        check_word("data held under stall", held_data, os_data);
        check_flag("last held under stall", held_last, os_last);
      end
      stall_q   = os_valid && !os_ready;
      held_data = os_data;
      held_last = os_last;
      if (os_valid && os_ready) begin
        set_words[beat_idx] = os_data;
        check_flag("last on beat 3", beat_idx == 3, os_last);
        if (beat_idx == 3) begin
          record_set();
          beat_idx = 0;
        end else begin
          beat_idx++;
        end
      end
    end
  end

  task automatic wait_sets(int n);
    do begin
      @(negedge clk_i);
    end while (set_kinds.size() < n);
  endtask

  task automatic wait_outcome();
    do begin
      @(negedge clk_i);
    end while (!success && !error);
  endtask

  task automatic check_sequence(int n_pad, int n_lane0, int n_ts2, int n_idle);
    os_kind_e exp_kind;
    logic     exp_lane;
    check_count("number of sets", n_pad + n_lane0 + n_ts2 + n_idle, set_kinds.size());
    for (int i = 0; i < set_kinds.size(); i++) begin
      exp_kind = OS_IDLE;
      exp_lane = 1'b1;
      if (i < n_pad) begin
        exp_kind = OS_TS1;
        exp_lane = 1'b0;
      end else if (i < n_pad + n_lane0) begin
        exp_kind = OS_TS1;
      end else if (i < n_pad + n_lane0 + n_ts2) begin
        exp_kind = OS_TS2;
      end
      check_kind($sformatf("kind of set %0d", i), exp_kind, set_kinds[i]);
      check_flag($sformatf("lane number of set %0d", i), exp_lane, set_lanes[i]);
    end
  endtask

  // timer clears one edge after the drive edge and expires limit edges later
  task automatic check_deadline(int drive_edge, logic [31:0] limit);
    int deadline;
    deadline = drive_edge + int'(limit) + 2;
    if (last_done < deadline) begin
      report_failure("error raised before the timer could have expired");
    end
    if (prev_done >= deadline) begin
      report_failure("error not raised at the first set end after the timer expired");
    end
  endtask

  task automatic begin_test(string name);
    test_name    = name;
    err_at_start = err_cnt;
    set_kinds.delete();
    set_lanes.delete();
    @(posedge clk_i);
    en <= 1'b1;
    start_edge = cyc;
  endtask

  task automatic end_test(logic exp_success, logic exp_error);
    @(posedge clk_i);
    en            <= 1'b0;
    width_sat     <= '0;
    lanes_formed  <= 1'b0;
    nums_match    <= 1'b0;
    lane_reconfig <= 1'b0;
    complete_ts2  <= '0;
    idle_rcvd     <= 1'b0;
    idle_sat      <= 1'b0;
    @(negedge clk_i);
    check_flag("success held until enable low", exp_success, success);
    check_flag("error held until enable low", exp_error, error);
    @(negedge clk_i);
    check_flag("success after enable drop", 1'b0, success);
    check_flag("error after enable drop", 1'b0, error);
    test_cnt++;
    if (err_cnt == err_at_start) begin
      $display("test %s: ok", test_name);
    end else begin
      $display("test %s: %0d errors", test_name, err_cnt - err_at_start);
    end
  endtask

  task automatic run_training(string name, int reconfigs, logic complete_ok);
    int                   n_width;
    int                   n_ts2;
    int                   base;
    int                   match_edge;
    logic [NUM_LANES-1:0] lanes;
    n_width = 1 + int'($urandom % 5);
    n_ts2   = 1 + int'($urandom % 4);
    lanes   = '0;
    while (lanes == '0) begin
      lanes = NUM_LANES'($urandom);
    end
    begin_test(name);
    // reported after n_width sets, decided at the end of the next one
    wait_sets(n_width);
    @(posedge clk_i);
    width_sat    <= lanes;
    lanes_formed <= 1'b1;
    wait_sets(n_width + 2);
    for (int r = 0; r < reconfigs; r++) begin
      @(posedge clk_i);
      lane_reconfig <= 1'b1;
      @(posedge clk_i);
      lane_reconfig <= 1'b0;
      wait_sets(n_width + 3 + r);
    end
    @(posedge clk_i);
    nums_match <= 1'b1;
    match_edge = cyc;
    base = n_width + 2 + reconfigs;
    if (complete_ok) begin
      wait_sets(base + n_ts2);
      @(posedge clk_i);
      complete_ts2 <= '1;
      idle_rcvd    <= 1'b1;
      idle_sat     <= 1'b1;
      wait_outcome();
      check_flag("success", 1'b1, success);
      check_flag("error", 1'b0, error);
      check_sequence(n_width + 1, 1 + reconfigs, n_ts2 + 1, IDLE_SETS_MIN + 1);
    end else begin
      wait_outcome();
      check_flag("success", 1'b0, success);
      check_flag("error", 1'b1, error);
      check_sequence(n_width + 1, 1 + reconfigs, set_kinds.size() - base, 0);
      check_deadline(match_edge, SHORT_CYC);
    end
    check_count("edge after deciding set", last_done + 1, cyc);
    end_test(complete_ok, !complete_ok);
  endtask

  task automatic run_width_timeout();
    begin_test("width_timeout");
    wait_outcome();
    check_flag("success", 1'b0, success);
    check_flag("error", 1'b1, error);
    check_sequence(set_kinds.size(), 0, 0, 0);
    check_deadline(start_edge, LONG_CYC);
    check_count("edge after deciding set", last_done + 1, cyc);
    end_test(1'b0, 1'b1);
  endtask

  initial begin
    void'($urandom(SEED));
    rst_i         = 1'b1;
    en            = 1'b0;
    width_sat     = '0;
    lanes_formed  = 1'b0;
    nums_match    = 1'b0;
    lane_reconfig = 1'b0;
    complete_ts2  = '0;
    idle_rcvd     = 1'b0;
    idle_sat      = 1'b0;
    repeat (16) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);
    run_training("normal", 0, 1'b1);
    run_training("lane_reconfig", 1 + int'($urandom % 3), 1'b1);
    run_width_timeout();
    run_training("complete_timeout", 0, 1'b0);
    $display("tests run: %0d, checks failed: %0d", test_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYC) @(posedge clk_i);
    $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYC);
    $display("TB FAILED");
    $finish;
  end

endmodule

//--- hdl/ltssm_cfg_top.sv
// ==================
// LTSSM Configuration top
// ==================
`timescale 1ns/10ps

module ltssm_cfg_top
  import ltssm_cfg_pkg::*;
#(
  parameter logic [7:0]  LINK_NUM          = 8'd0,
  parameter int          NUM_LANES         = 4,
  parameter logic [31:0] LONG_TIMEOUT_CYC  = 32'd6_000_000,
  parameter logic [31:0] SHORT_TIMEOUT_CYC = 32'd500_000,
  parameter int          IDLE_SETS_MIN     = 16
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 en_i,
  input  logic [NUM_LANES-1:0] link_width_satisfied_i,
  input  logic                 link_lanes_formed_i,
  input  logic                 link_lanes_nums_match_i,
  input  logic                 link_lane_reconfig_i,
  input  logic [NUM_LANES-1:0] config_complete_ts2_i,
  input  logic                 single_idle_received_i,
  input  logic                 link_idle_satisfied_i,
  input  logic                 os_ready_i,
  output os_word_t             os_data_o,
  output logic                 os_valid_o,
  output logic                 os_last_o,
  output logic                 success_o,
  output logic                 error_o
);

  logic       send;
  os_kind_e   kind;
  logic       lane_valid;
  logic       tx_done;
  logic       timer_clear;
  timer_lim_e timer_lim;
  logic       timer_expired;

  cfg_state_ctrl #(
    .NUM_LANES    (NUM_LANES),
    .IDLE_SETS_MIN(IDLE_SETS_MIN)
  ) u_ctrl (
    .clk_i                  (clk_i),
    .rst_i                  (rst_i),
    .en_i                   (en_i),
    .link_width_satisfied_i (link_width_satisfied_i),
    .link_lanes_formed_i    (link_lanes_formed_i),
    .link_lanes_nums_match_i(link_lanes_nums_match_i),
    .link_lane_reconfig_i   (link_lane_reconfig_i),
    .config_complete_ts2_i  (config_complete_ts2_i),
    .single_idle_received_i (single_idle_received_i),
    .link_idle_satisfied_i  (link_idle_satisfied_i),
    .tx_done_i              (tx_done),
    .expired_i              (timer_expired),
    .send_o                 (send),
    .kind_o                 (kind),
    .lane_valid_o           (lane_valid),
    .clear_o                (timer_clear),
    .lim_o                  (timer_lim),
    .success_o              (success_o),
    .error_o                (error_o)
  );

  cfg_timeout_timer #(
    .LONG_TIMEOUT_CYC (LONG_TIMEOUT_CYC),
    .SHORT_TIMEOUT_CYC(SHORT_TIMEOUT_CYC)
  ) u_timer (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .clear_i  (timer_clear),
    .lim_i    (timer_lim),
    .expired_o(timer_expired)
  );

  os_beat_tx #(
    .LINK_NUM(LINK_NUM)
  ) u_tx (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .send_i      (send),
    .kind_i      (kind),
    .lane_valid_i(lane_valid),
    .os_ready_i  (os_ready_i),
    .os_data_o   (os_data_o),
    .os_valid_o  (os_valid_o),
    .os_last_o   (os_last_o),
    .tx_done_o   (tx_done)
  );

endmodule

//--- hdl/cfg_state_ctrl.sv
// ==================
// Configuration substate FSM
// ==================
`timescale 1ns/10ps

module cfg_state_ctrl
  import ltssm_cfg_pkg::*;
#(
  parameter int NUM_LANES     = 4,
  parameter int IDLE_SETS_MIN = 16
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 en_i,
  input  logic [NUM_LANES-1:0] link_width_satisfied_i,
  input  logic                 link_lanes_formed_i,
  input  logic                 link_lanes_nums_match_i,
  input  logic                 link_lane_reconfig_i,
  input  logic [NUM_LANES-1:0] config_complete_ts2_i,
  input  logic                 single_idle_received_i,
  input  logic                 link_idle_satisfied_i,
  input  logic                 tx_done_i,
  input  logic                 expired_i,
  output logic                 send_o,
  output os_kind_e             kind_o,
  output logic                 lane_valid_o,
  output logic                 clear_o,
  output timer_lim_e           lim_o,
  output logic                 success_o,
  output logic                 error_o
);

  localparam int IDLE_CNT_W = $clog2(IDLE_SETS_MIN + 1);
  localparam logic [IDLE_CNT_W-1:0] IDLE_CNT_MAX = IDLE_CNT_W'(IDLE_SETS_MIN);

  cfg_state_e            state_q, state_d;
  logic                  send_q, send_d;
  os_kind_e              kind_q, kind_d;
  logic                  lane_q, lane_d;
  timer_lim_e            lim_q, lim_d;
  logic                  success_q, success_d;
  logic                  error_q, error_d;
  logic [IDLE_CNT_W-1:0] idle_cnt_q, idle_cnt_d;
  logic                  clear_c;
  logic                  set_pending_q;

  always_comb begin
    state_d    = state_q;
    send_d     = 1'b0;
    kind_d     = kind_q;
    lane_d     = lane_q;
    lim_d      = lim_q;
    success_d  = success_q;
    error_d    = error_q;
    idle_cnt_d = idle_cnt_q;
    clear_c    = 1'b0;
    case (state_q)
      IDLE: begin
        if (en_i) begin
          state_d = WIDTH_START;
          clear_c = 1'b1;
          lim_d   = LIM_LONG;
          send_d  = 1'b1;
          kind_d  = OS_TS1;
          lane_d  = 1'b0;
        end
      end
      WIDTH_START: begin
        if (tx_done_i) begin
          if (|link_width_satisfied_i) begin
            state_d = WIDTH_ACCEPT;
            clear_c = 1'b1;
            lim_d   = LIM_SHORT;
          end else if (expired_i) begin
            error_d = 1'b1;
            state_d = WAIT_EN_LOW;
          end else begin
            send_d = 1'b1;
          end
        end
      end
      WIDTH_ACCEPT: begin
        if (link_lanes_formed_i) begin
          // lane number 0 from here on
          send_d  = 1'b1;
          kind_d  = OS_TS1;
          lane_d  = 1'b1;
          state_d = LANENUM_WAIT;
        end else if (expired_i) begin
          error_d = 1'b1;
          state_d = WAIT_EN_LOW;
        end
      end
      LANENUM_WAIT: begin
        if (tx_done_i) begin
          state_d = LANENUM_ACCEPT;
        end
      end
      LANENUM_ACCEPT: begin
        if (link_lanes_nums_match_i) begin
          state_d = COMPLETE;
          clear_c = 1'b1;
          send_d  = 1'b1;
          kind_d  = OS_TS2;
        end else if (link_lane_reconfig_i) begin
          send_d  = 1'b1;
          state_d = LANENUM_WAIT;
        end
      end
      COMPLETE: begin
        if (tx_done_i) begin
          if (&config_complete_ts2_i) begin
            state_d    = CFG_IDLE;
            clear_c    = 1'b1;
            send_d     = 1'b1;
            kind_d     = OS_IDLE;
            idle_cnt_d = '0;
          end else if (expired_i) begin
            error_d = 1'b1;
            state_d = WAIT_EN_LOW;
          end else begin
            send_d = 1'b1;
          end
        end
      end
      CFG_IDLE: begin
        if (tx_done_i) begin
          if (single_idle_received_i && idle_cnt_q != IDLE_CNT_MAX) begin
            idle_cnt_d = idle_cnt_q + 1'b1;
          end
          // count before this set's increment
          if (link_idle_satisfied_i && idle_cnt_q >= IDLE_CNT_MAX) begin
            success_d = 1'b1;
            state_d   = WAIT_EN_LOW;
          end else if (expired_i) begin
            error_d = 1'b1;
            state_d = WAIT_EN_LOW;
          end else begin
            send_d = 1'b1;
          end
        end
      end
      WAIT_EN_LOW: begin
        if (!en_i) begin
          success_d = 1'b0;
          error_d   = 1'b0;
          state_d   = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q    <= IDLE;
      send_q     <= 1'b0;
      kind_q     <= OS_TS1;
      lane_q     <= 1'b0;
      lim_q      <= LIM_LONG;
      success_q  <= 1'b0;
      error_q    <= 1'b0;
      idle_cnt_q <= '0;
    end else begin
      state_q    <= state_d;
      send_q     <= send_d;
      kind_q     <= kind_d;
      lane_q     <= lane_d;
      lim_q      <= lim_d;
      success_q  <= success_d;
      error_q    <= error_d;
      idle_cnt_q <= idle_cnt_d;
    end
  end

  // set handed to the transmitter and not yet done
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      set_pending_q <= 1'b0;
    end else if (send_q) begin
      set_pending_q <= 1'b1;
    end else if (tx_done_i) begin
      set_pending_q <= 1'b0;
    end
  end

  assign send_o       = send_q;
  assign kind_o       = kind_q;
  assign lane_valid_o = lane_q;
  assign clear_o      = clear_c;
  assign lim_o        = lim_q;
  assign success_o    = success_q;
  assign error_o      = error_q;

  a_send_idle: assert property (@(posedge clk_i) disable iff (rst_i)
    send_q |-> !set_pending_q);

  a_one_outcome: assert property (@(posedge clk_i) disable iff (rst_i)
    !(success_q && error_q));

endmodule

//--- hdl/os_beat_tx.sv
// ==================
// Ordered set beat transmitter
// ==================
`timescale 1ns/10ps

module os_beat_tx
  import ltssm_cfg_pkg::*;
#(
  parameter logic [7:0] LINK_NUM = 8'd0
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     send_i,
  input  os_kind_e kind_i,
  input  logic     lane_valid_i,
  input  logic     os_ready_i,
  output os_word_t os_data_o,
  output logic     os_valid_o,
  output logic     os_last_o,
  output logic     tx_done_o
);

  os_kind_e  kind_q;
  logic      lane_q;
  beat_idx_t beat_q;
  logic      valid_q;
  logic      hs;
  logic      last_beat;

  assign hs        = valid_q && os_ready_i;
  assign last_beat = (beat_q == beat_idx_t'(BEATS_PER_OS - 1));

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
      beat_q  <= '0;
    end else if (send_i) begin
      valid_q <= 1'b1;
      beat_q  <= '0;
    end else if (hs) begin
      // wraps to 0 after beat 3
      beat_q <= beat_q + 2'd1;
      if (last_beat) begin
        valid_q <= 1'b0;
      end
    end
  end

  // set content, held for the whole set
  always_ff @(posedge clk_i) begin
    if (send_i) begin
      kind_q <= kind_i;
      lane_q <= lane_valid_i;
    end
  end

  ts_os_builder #(
    .LINK_NUM(LINK_NUM)
  ) u_builder (
    .kind_i      (kind_q),
    .lane_valid_i(lane_q),
    .beat_i      (beat_q),
    .word_o      (os_data_o)
  );

  assign os_valid_o = valid_q;
  assign os_last_o  = valid_q && last_beat;
  assign tx_done_o  = hs && last_beat;

  // stalled beat must not change
  a_hold_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    (valid_q && !os_ready_i) |=> (valid_q && $stable(os_data_o) && $stable(os_last_o)));

endmodule

//--- hdl/ts_os_builder.sv
// ==================
// Ordered set word builder
// ==================
`timescale 1ns/10ps

module ts_os_builder
  import ltssm_cfg_pkg::*;
#(
  parameter logic [7:0] LINK_NUM = 8'd0
) (
  input  os_kind_e  kind_i,
  input  logic      lane_valid_i,
  input  beat_idx_t beat_i,
  output os_word_t  word_o
);

  logic [7:0] ts_id;
  logic [7:0] lane_sym;
  logic [3:0] base;
  logic [7:0] sym [16];

  assign ts_id    = (kind_i == OS_TS2) ? TS2_ID : TS1_ID;
  assign lane_sym = lane_valid_i ? 8'h00 : SYM_PAD;
  assign base     = {beat_i, 2'b00};

  // symbol table shared by TS1 and TS2
  always_comb begin
    sym[0] = SYM_COM;
    sym[1] = LINK_NUM;
    sym[2] = lane_sym;
    sym[3] = N_FTS_VAL;
    sym[4] = RATE_ID_VAL;
    // training control
    sym[5] = 8'h00;
    for (int i = 6; i < 16; i++) begin
      sym[i] = ts_id;
    end
  end

  always_comb begin
    word_o = '0;
    // idle sets stay all zero
    if (kind_i == OS_TS1 || kind_i == OS_TS2) begin
      for (int k = 0; k < 4; k++) begin
        word_o[8*k +: 8] = sym[base + 4'(k)];
      end
    end
  end

endmodule

//--- hdl/cfg_timeout_timer.sv
// ==================
// Configuration timeout timer
// ==================
`timescale 1ns/10ps

module cfg_timeout_timer
  import ltssm_cfg_pkg::*;
#(
  parameter logic [31:0] LONG_TIMEOUT_CYC  = 32'd6_000_000,
  parameter logic [31:0] SHORT_TIMEOUT_CYC = 32'd500_000
) (
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       clear_i,
  input  timer_lim_e lim_i,
  output logic       expired_o
);

  logic [31:0] cnt_q;
  logic [31:0] limit;

  assign limit = (lim_i == LIM_LONG) ? LONG_TIMEOUT_CYC : SHORT_TIMEOUT_CYC;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else if (clear_i) begin
      cnt_q <= '0;
    end else if (cnt_q < limit) begin
      cnt_q <= cnt_q + 32'd1;
    end else begin
      // also pulls back after a switch to the short limit
      cnt_q <= limit;
    end
  end

  assign expired_o = (cnt_q >= limit);

endmodule

//--- hdl/ltssm_cfg_pkg.sv
// ==================
// LTSSM Configuration shared types
// ==================

package ltssm_cfg_pkg;

  // controller substates
  typedef enum logic [3:0] {
    IDLE,
    WIDTH_START,
    WIDTH_ACCEPT,
    LANENUM_WAIT,
    LANENUM_ACCEPT,
    COMPLETE,
    CFG_IDLE,
    WAIT_EN_LOW
  } cfg_state_e;

  typedef enum logic [1:0] {
    OS_TS1,
    OS_TS2,
    OS_IDLE
  } os_kind_e;

  // 24 ms class or 2 ms class
  typedef enum logic {
    LIM_LONG,
    LIM_SHORT
  } timer_lim_e;

  // symbol 0 in the low byte
  typedef logic [31:0] os_word_t;
  typedef logic [1:0]  beat_idx_t;

  localparam int BEATS_PER_OS = 4;

  localparam logic [7:0] SYM_COM     = 8'hBC;
  localparam logic [7:0] SYM_PAD     = 8'hF7;
  localparam logic [7:0] TS1_ID      = 8'h4A;
  localparam logic [7:0] TS2_ID      = 8'h45;
  localparam logic [7:0] N_FTS_VAL   = 8'h1F;
  // 2.5 GT/s only
  localparam logic [7:0] RATE_ID_VAL = 8'h02;

endpackage
